// File: build.f
verilog/dcachePkg.sv
verilog/wayArray.sv
verilog/lineState.sv
verilog/refillBuffer.sv
verilog/storeMerge.sv
verilog/cacheCtrl.sv
verilog/dcacheTop.sv
verification/dcacheTb.sv

// File: verification/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  localparam int NumRequests   = 600;
  localparam int TimeoutCycles = NumRequests * 45;

  logic                         clk;
  logic                         rst_n;
  logic                         reqValid_i;
  dcachePkg::cpuReq_t           req_i;
  logic                         reqReady_o;
  logic                         rspValid_o;
  logic [dcachePkg::WordW-1:0]  rdData_o;
  logic                         memRdValid_o;
  logic [dcachePkg::AddrW-1:0]  memRdAddr_o;
  logic                         memRdReady_i;
  logic                         memRdDataValid_i;
  logic [dcachePkg::WordW-1:0]  memRdData_i;
  logic                         memRdLast_i;
  logic                         memWrValid_o;
  dcachePkg::memWrReq_t         memWrReq_o;
  logic                         memWrReady_i;

  // reference model of the cache and backing memory
  logic [dcachePkg::TagW-1:0]   mTag   [2][dcachePkg::NumSets];
  logic [dcachePkg::LineW-1:0]  mLine  [2][dcachePkg::NumSets];
  bit                           mValid [2][dcachePkg::NumSets];
  bit                           mDirty [2][dcachePkg::NumSets];
  bit                           mRepl;
  logic [dcachePkg::WordW-1:0]  memory [logic [dcachePkg::AddrW-1:0]];
  int                           errors;
  int                           checks;
  int                           cycleCnt;

  dcacheTop i_dcacheTop (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .req_i            (req_i),
    .reqReady_o       (reqReady_o),
    .rspValid_o       (rspValid_o),
    .rdData_o         (rdData_o),
    .memRdValid_o     (memRdValid_o),
    .memRdAddr_o      (memRdAddr_o),
    .memRdReady_i     (memRdReady_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdData_i      (memRdData_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrReq_o       (memWrReq_o),
    .memWrReady_i     (memWrReady_i)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // unwritten words get a pattern built from the full address
  function automatic logic [63:0] memWord(input logic [31:0] addr);
    if (memory.exists(addr)) begin
      return memory[addr];
    end
    return {addr ^ 32'h5a5a_0f0f, ~addr};
  endfunction

  function automatic logic [31:0] makeAddr(input int tagSel, input int idx, input int off);
    return {21'h100000 | 21'(tagSel), 6'(idx), 5'(off)};
  endfunction

  function automatic dcachePkg::cpuReq_t randomReq(input bit isStore, input logic [31:0] addr);
    dcachePkg::cpuReq_t r;
    r.addr    = addr;
    r.isStore = isStore;
    r.wrData  = {$urandom, $urandom};
    r.wrMask  = isStore ? 8'($urandom) : 8'h00;
    return r;
  endfunction

  task automatic checkValue(input string name, input logic [287:0] expected,
                            input logic [287:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // predicts one access and updates the model state
  task automatic modelAccess(input dcachePkg::cpuReq_t req, output bit hit, output bit wb,
                             output dcachePkg::memWrReq_t wbReq, output logic [63:0] rdWord);
    logic [20:0] tag;
    logic [5:0]  idx;
    logic [63:0] word;
    int          way;
    int          off;
    tag   = req.addr[31:11];
    idx   = req.addr[10:5];
    off   = req.addr[2:0];
    way   = -1;
    wb    = 1'b0;
    wbReq = '0;
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][idx] && mTag[w][idx] == tag) begin
        way = w;
      end
    end
    hit = (way >= 0);
    if (!hit) begin
      way = mRepl;
      if (mValid[way][idx] && mDirty[way][idx]) begin
        wb         = 1'b1;
        wbReq.addr = {mTag[way][idx], idx, 5'b0};
        wbReq.line = mLine[way][idx];
        for (int b = 0; b < 4; b++) begin
          memory[wbReq.addr + b * 8] = wbReq.line[b*64 +: 64];
        end
      end
      for (int b = 0; b < 4; b++) begin
        mLine[way][idx][b*64 +: 64] = memWord({tag, idx, 5'b0} + b * 8);
      end
      mTag[way][idx]   = tag;
      mValid[way][idx] = 1'b1;
      mDirty[way][idx] = 1'b0;
      mRepl            = !mRepl;
    end
    word   = mLine[way][idx][req.addr[4:3]*64 +: 64];
    rdWord = req.isStore ? 64'h0 : word;
    if (req.isStore) begin
      // byte b of the word takes store byte b - off when enabled
      for (int b = 0; b < 8; b++) begin
        if (b >= off && req.wrMask[b - off]) begin
          word[b*8 +: 8] = req.wrData[(b - off)*8 +: 8];
        end
      end
      mLine[way][idx][req.addr[4:3]*64 +: 64] = word;
      mDirty[way][idx] = 1'b1;
    end
  endtask

  // issues one request and plays the bus until the response
  task automatic runRequest(input string name, input dcachePkg::cpuReq_t req);
    bit                   expHit;
    bit                   expWb;
    dcachePkg::memWrReq_t expWbReq;
    logic [63:0]          expData;
    logic [63:0]          beatData;
    logic [31:0]          rdAddr;
    int                   cycles;
    int                   rdCnt;
    int                   wrCnt;
    int                   rdWait;
    int                   wrWait;
    int                   beatIdx;
    int                   gap;
    bit                   done;
    bit                   rdRdy;
    bit                   wrRdy;
    bit                   rdActive;
    bit                   beatNow;
    bit                   beatLast;
    modelAccess(req, expHit, expWb, expWbReq, expData);
    cycles   = 0;
    rdCnt    = 0;
    wrCnt    = 0;
    beatIdx  = 0;
    gap      = 0;
    done     = 1'b0;
    rdRdy    = 1'b0;
    wrRdy    = 1'b0;
    rdActive = 1'b0;
    rdWait   = -1;
    wrWait   = -1;
    rdAddr   = '0;
    beatData = '0;
    reqValid_i <= 1'b1;
    req_i      <= req;
    @(negedge clk);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    reqValid_i <= 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      beatNow  = 1'b0;
      beatLast = 1'b0;
      // no new request is taken while one is in flight
      checkValue({name, " ready low"}, 0, reqReady_o);
      if (memWrValid_o) begin
        checkValue({name, " wb addr"}, expWbReq.addr, memWrReq_o.addr);
        checkValue({name, " wb line"}, expWbReq.line, memWrReq_o.line);
      end
      if (memWrValid_o && memWrReady_i) begin
        wrCnt++;
        wrRdy  = 1'b0;
        wrWait = -1;
      end else if (memWrValid_o) begin
        if (wrWait < 0) wrWait = $urandom % 4;
        if (wrWait == 0) wrRdy = 1'b1;
        else wrWait--;
      end
      if (memRdValid_o) begin
        checkValue({name, " read addr"}, {req.addr[31:5], 5'b0}, memRdAddr_o);
      end
      if (memRdValid_o && memRdReady_i) begin
        rdCnt++;
        checkValue({name, " wb before read"}, expWb, wrCnt);
        rdAddr   = memRdAddr_o;
        rdRdy    = 1'b0;
        rdWait   = -1;
        rdActive = 1'b1;
        gap      = $urandom % 3;
      end else if (memRdValid_o) begin
        if (rdWait < 0) rdWait = $urandom % 4;
        if (rdWait == 0) rdRdy = 1'b1;
        else rdWait--;
      end
      if (rdActive && gap > 0) begin
        gap--;
      end else if (rdActive) begin
        beatNow  = 1'b1;
        beatData = memWord(rdAddr + beatIdx * 8);
        beatLast = (beatIdx == 3);
        beatIdx++;
        rdActive = (beatIdx < 4);
        gap      = $urandom % 3;
      end
      if (rspValid_o) begin
        done = 1'b1;
        checkValue({name, " data"}, expData, rdData_o);
        checkValue({name, " bus idle"}, 0, {memRdValid_o, memWrValid_o});
        checkValue({name, " reads"}, expHit ? 0 : 1, rdCnt);
        checkValue({name, " writes"}, expWb, wrCnt);
        if (expHit) checkValue({name, " hit latency"}, 1, cycles);
        else checkValue({name, " beats"}, 4, beatIdx);
      end
      @(posedge clk);
      memWrReady_i     <= wrRdy;
      memRdReady_i     <= rdRdy;
      memRdDataValid_i <= beatNow;
      memRdData_i      <= beatNow ? beatData : 64'h0;
      memRdLast_i      <= beatLast;
    end
  endtask

  initial begin
    int tagSel;
    int idx;
    int off;
    bit isStore;
    void'($urandom(20301));
    rst_n            = 1'b0;
    reqValid_i       = 1'b0;
    req_i            = '0;
    memRdReady_i     = 1'b0;
    memRdDataValid_i = 1'b0;
    memRdData_i      = '0;
    memRdLast_i      = 1'b0;
    memWrReady_i     = 1'b0;
    errors           = 0;
    checks           = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("reset ready", 1, reqReady_o);
    checkValue("reset valids", 0, {rspValid_o, memRdValid_o, memWrValid_o});
    @(posedge clk);
    // cold miss, store merge into word 1, then a plain hit
    runRequest("cold load", randomReq(1'b0, makeAddr(1, 10, 8)));
    runRequest("store merge", randomReq(1'b1, makeAddr(1, 10, 11)));
    runRequest("load after store", randomReq(1'b0, makeAddr(1, 10, 11)));
    runRequest("repeat load", randomReq(1'b0, makeAddr(1, 10, 8)));
    // a third tag in a set with both ways dirty forces a writeback
    runRequest("dirty fill a", randomReq(1'b1, makeAddr(2, 20, 0)));
    runRequest("dirty fill b", randomReq(1'b1, makeAddr(3, 20, 16)));
    runRequest("dirty evict", randomReq(1'b0, makeAddr(4, 20, 24)));
    runRequest("dirty evict again", randomReq(1'b1, makeAddr(2, 20, 5)));
    // clean victims only
    runRequest("clean fill a", randomReq(1'b0, makeAddr(5, 30, 0)));
    runRequest("clean fill b", randomReq(1'b0, makeAddr(6, 30, 8)));
    runRequest("clean evict", randomReq(1'b0, makeAddr(7, 30, 16)));
    for (int i = 0; i < NumRequests - 11; i++) begin
      tagSel  = $urandom % 4;
      idx     = $urandom % 4;
      off     = $urandom % 32;
      isStore = $urandom % 2;
      runRequest("random mix", randomReq(isStore, makeAddr(tagSel, idx, off)));
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    cycleCnt = 0;
    while (cycleCnt < TimeoutCycles) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("timeout: run did not finish within %0d cycles, errors: %0d",
             TimeoutCycles, errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: verilog/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              reqValid_i,
  input  dcachePkg::cpuReq_t                req_i,
  output logic                              reqReady_o,
  output logic                              rspValid_o,
  output logic [dcachePkg::WordW-1:0]       rdData_o,
  output logic                              memRdValid_o,
  output logic [dcachePkg::AddrW-1:0]       memRdAddr_o,
  input  logic                              memRdReady_i,
  output logic                              memWrValid_o,
  output dcachePkg::memWrReq_t              memWrReq_o,
  input  logic                              memWrReady_i,
  input  dcachePkg::tagEntry_t [1:0]        tagQ_i,
  input  logic [1:0][dcachePkg::LineW-1:0]  dataQ_i,
  output logic [dcachePkg::IndexW-1:0]      index_o,
  output logic                              arrayEn_o,
  output logic [1:0]                        tagWe_o,
  output logic [1:0]                        dataWe_o,
  output dcachePkg::tagEntry_t              tagD_o,
  output dcachePkg::lineWrite_t             dataD_o,
  input  logic [1:0]                        valid_i,
  input  logic [1:0]                        dirty_i,
  input  logic                              victim_i,
  output logic                              setValid_o,
  output logic                              setDirty_o,
  output logic                              clearDirty_o,
  output logic                              hitWay_o,
  input  logic [dcachePkg::LineW-1:0]       refillLine_i,
  input  logic                              refillDone_i,
  output dcachePkg::cpuReq_t                latchedReq_o,
  input  dcachePkg::lineWrite_t             storeWrite_i
);

  dcachePkg::ctrlState_t         state;
  dcachePkg::ctrlState_t         nextState;
  dcachePkg::cpuReq_t            reqQ;
  logic                          bypassQ;
  logic                          fillWayQ;
  logic [dcachePkg::TagW-1:0]    reqTag;
  logic [dcachePkg::IndexW-1:0]  reqIndex;
  logic [1:0]                    wordSel;
  logic [1:0]                    tagMatch;
  logic [1:0]                    hitVec;
  logic                          hit;
  logic                          hitWay;
  logic                          accept;
  logic                          compareHit;
  logic                          storeHit;
  logic                          replacing;
  logic [dcachePkg::LineW-1:0]   hitLine;

  assign reqTag   = reqQ.addr[dcachePkg::AddrW-1 -: dcachePkg::TagW];
  assign reqIndex = reqQ.addr[dcachePkg::OffsetW +: dcachePkg::IndexW];
  assign wordSel  = reqQ.addr[dcachePkg::OffsetW-1 -: 2];

  assign reqReady_o = (state == dcachePkg::IDLE);
  assign accept     = reqValid_i && reqReady_o;
  assign replacing  = (state == dcachePkg::REPLACE);

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::IDLE:    if (reqValid_i) nextState = dcachePkg::COMPARE;
      dcachePkg::COMPARE: begin
        if (hit) begin
          nextState = dcachePkg::IDLE;
        end else if (valid_i[victim_i] && dirty_i[victim_i]) begin
          nextState = dcachePkg::WRBACK;
        end else begin
          nextState = dcachePkg::MISS;
        end
      end
      dcachePkg::WRBACK:  if (memWrReady_i) nextState = dcachePkg::MISS;
      dcachePkg::MISS:    if (memRdReady_i) nextState = dcachePkg::REFILL;
      dcachePkg::REFILL:  if (refillDone_i) nextState = dcachePkg::REPLACE;
      dcachePkg::REPLACE: nextState = dcachePkg::COMPARE;
      default:            nextState = dcachePkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= dcachePkg::IDLE;
      bypassQ  <= 1'b0;
      fillWayQ <= 1'b0;
    end else begin
      state   <= nextState;
      bypassQ <= replacing;
      if (replacing) begin
        fillWayQ <= victim_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
  end

  // arrays are read with the incoming index while idle
  assign index_o = reqReady_o ? req_i.addr[dcachePkg::OffsetW +: dcachePkg::IndexW] : reqIndex;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      tagMatch[w] = valid_i[w] && (tagQ_i[w].tag == reqTag);
    end
  end

  // right after a refill the array output is stale, so the filled way hits
  assign hitVec     = bypassQ ? (2'b01 << fillWayQ) : tagMatch;
  assign hit        = |hitVec;
  assign hitWay     = hitVec[1];
  assign compareHit = (state == dcachePkg::COMPARE) && hit;
  assign storeHit   = compareHit && reqQ.isStore;

  assign hitLine    = bypassQ ? refillLine_i : dataQ_i[hitWay];
  assign rspValid_o = compareHit;
  assign rdData_o   = (compareHit && !reqQ.isStore) ?
                      hitLine[wordSel*dcachePkg::WordW +: dcachePkg::WordW] : '0;

  assign tagWe_o    = replacing ? (2'b01 << victim_i) : 2'b00;
  assign dataWe_o   = replacing ? (2'b01 << victim_i) :
                      storeHit  ? (2'b01 << hitWay)   : 2'b00;
  assign arrayEn_o  = accept || (|dataWe_o);
  assign tagD_o.tag = reqTag;

  always_comb begin
    if (replacing) begin
      dataD_o.data    = refillLine_i;
      dataD_o.bitMask = '1;
    end else begin
      dataD_o = storeWrite_i;
    end
  end

  assign setValid_o   = replacing;
  assign clearDirty_o = replacing;
  assign setDirty_o   = storeHit;
  assign hitWay_o     = replacing ? victim_i : hitWay;
  assign latchedReq_o = reqQ;

  assign memRdValid_o    = (state == dcachePkg::MISS);
  assign memRdAddr_o     = {reqTag, reqIndex, {dcachePkg::OffsetW{1'b0}}};
  // victim tag and line stay in the array output regs until the next access
  assign memWrValid_o    = (state == dcachePkg::WRBACK);
  assign memWrReq_o.addr = {tagQ_i[victim_i].tag, reqIndex, {dcachePkg::OffsetW{1'b0}}};
  assign memWrReq_o.line = dataQ_i[victim_i];

  busExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_o && memWrValid_o));

  rspInCompare: assert property (@(posedge clk) disable iff (!rst_n)
    rspValid_o |-> state == dcachePkg::COMPARE);

  rdReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o && !memRdReady_i |=> memRdValid_o && $stable(memRdAddr_o));

endmodule

// File: verilog/dcachePkg.sv
package dcachePkg;

  localparam int AddrW        = 32;
  localparam int WordW        = 64;
  localparam int LineW        = 256;
  localparam int OffsetW      = 5;
  localparam int IndexW       = 6;
  localparam int TagW         = 21;
  localparam int NumSets      = 64;
  localparam int BeatsPerLine = 4;

  // one load or store from the pipeline
  typedef struct packed {
    logic [AddrW-1:0]   addr;
    logic               isStore;
    logic [WordW-1:0]   wrData;
    logic [WordW/8-1:0] wrMask;
  } cpuReq_t;

  // dirty line going back to memory at its line aligned address
  typedef struct packed {
    logic [AddrW-1:0] addr;
    logic [LineW-1:0] line;
  } memWrReq_t;

  typedef struct packed {
    logic [TagW-1:0] tag;
  } tagEntry_t;

  typedef struct packed {
    logic [LineW-1:0] data;
    logic [LineW-1:0] bitMask;
  } lineWrite_t;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    COMPARE = 3'd1,
    WRBACK  = 3'd2,
    MISS    = 3'd3,
    REFILL  = 3'd4,
    REPLACE = 3'd5
  } ctrlState_t;

endpackage

// File: verilog/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         reqValid_i,
  input  dcachePkg::cpuReq_t           req_i,
  output logic                         reqReady_o,
  output logic                         rspValid_o,
  output logic [dcachePkg::WordW-1:0]  rdData_o,
  output logic                         memRdValid_o,
  output logic [dcachePkg::AddrW-1:0]  memRdAddr_o,
  input  logic                         memRdReady_i,
  input  logic                         memRdDataValid_i,
  input  logic [dcachePkg::WordW-1:0]  memRdData_i,
  input  logic                         memRdLast_i,
  output logic                         memWrValid_o,
  output dcachePkg::memWrReq_t         memWrReq_o,
  input  logic                         memWrReady_i
);

  dcachePkg::tagEntry_t [1:0]         tagQ;
  logic [1:0][dcachePkg::LineW-1:0]   dataQ;
  logic [dcachePkg::IndexW-1:0]       index;
  logic                               arrayEn;
  logic [1:0]                         tagWe;
  logic [1:0]                         dataWe;
  dcachePkg::tagEntry_t               tagD;
  dcachePkg::lineWrite_t              dataD;
  logic [1:0]                         valid;
  logic [1:0]                         dirty;
  logic                               victim;
  logic                               setValid;
  logic                               setDirty;
  logic                               clearDirty;
  logic                               hitWay;
  logic [dcachePkg::LineW-1:0]        refillLine;
  logic                               refillDone;
  dcachePkg::cpuReq_t                 latchedReq;
  dcachePkg::lineWrite_t              storeWrite;

  cacheCtrl i_cacheCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .req_i        (req_i),
    .reqReady_o   (reqReady_o),
    .rspValid_o   (rspValid_o),
    .rdData_o     (rdData_o),
    .memRdValid_o (memRdValid_o),
    .memRdAddr_o  (memRdAddr_o),
    .memRdReady_i (memRdReady_i),
    .memWrValid_o (memWrValid_o),
    .memWrReq_o   (memWrReq_o),
    .memWrReady_i (memWrReady_i),
    .tagQ_i       (tagQ),
    .dataQ_i      (dataQ),
    .index_o      (index),
    .arrayEn_o    (arrayEn),
    .tagWe_o      (tagWe),
    .dataWe_o     (dataWe),
    .tagD_o       (tagD),
    .dataD_o      (dataD),
    .valid_i      (valid),
    .dirty_i      (dirty),
    .victim_i     (victim),
    .setValid_o   (setValid),
    .setDirty_o   (setDirty),
    .clearDirty_o (clearDirty),
    .hitWay_o     (hitWay),
    .refillLine_i (refillLine),
    .refillDone_i (refillDone),
    .latchedReq_o (latchedReq),
    .storeWrite_i (storeWrite)
  );

  // tag and data storage, one pair per way
  for (genvar w = 0; w < 2; w++) begin : gWay
    wayArray #(
      .Depth   (dcachePkg::NumSets),
      .Payload (dcachePkg::tagEntry_t)
    ) i_tagArray (
      .clk       (clk),
      .en_i      (arrayEn),
      .we_i      (tagWe[w]),
      .addr_i    (index),
      .d_i       (tagD),
      .bitMask_i ('1),
      .q_o       (tagQ[w])
    );

    wayArray #(
      .Depth   (dcachePkg::NumSets),
      .Payload (logic [dcachePkg::LineW-1:0])
    ) i_dataArray (
      .clk       (clk),
      .en_i      (arrayEn),
      .we_i      (dataWe[w]),
      .addr_i    (index),
      .d_i       (dataD.data),
      .bitMask_i (dataD.bitMask),
      .q_o       (dataQ[w])
    );
  end

  lineState i_lineState (
    .clk          (clk),
    .rst_n        (rst_n),
    .index_i      (index),
    .hitWay_i     (hitWay),
    .setValid_i   (setValid),
    .setDirty_i   (setDirty),
    .clearDirty_i (clearDirty),
    .valid_o      (valid),
    .dirty_o      (dirty),
    .victim_o     (victim)
  );

  refillBuffer i_refillBuffer (
    .clk              (clk),
    .rst_n            (rst_n),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdData_i      (memRdData_i),
    .memRdLast_i      (memRdLast_i),
    .line_o           (refillLine),
    .done_o           (refillDone)
  );

  storeMerge i_storeMerge (
    .req_i   (latchedReq),
    .write_o (storeWrite)
  );

endmodule

// File: verilog/lineState.sv
`timescale 1ns/1ps

module lineState (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [dcachePkg::IndexW-1:0]  index_i,
  input  logic                          hitWay_i,
  input  logic                          setValid_i,
  input  logic                          setDirty_i,
  input  logic                          clearDirty_i,
  output logic [1:0]                    valid_o,
  output logic [1:0]                    dirty_o,
  output logic                          victim_o
);

  logic [1:0][dcachePkg::NumSets-1:0] validQ;
  logic [1:0][dcachePkg::NumSets-1:0] dirtyQ;
  logic                               replQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      replQ  <= 1'b0;
    end else begin
      // fill marks the way valid and moves the victim to the other way
      if (setValid_i) begin
        validQ[hitWay_i][index_i] <= 1'b1;
        replQ                     <= ~replQ;
      end
      if (setDirty_i) begin
        dirtyQ[hitWay_i][index_i] <= 1'b1;
      end else if (clearDirty_i) begin
        dirtyQ[hitWay_i][index_i] <= 1'b0;
      end
    end
  end

  assign valid_o  = {validQ[1][index_i], validQ[0][index_i]};
  assign dirty_o  = {dirtyQ[1][index_i], dirtyQ[0][index_i]};
  assign victim_o = replQ;

  dirtyExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(setDirty_i && clearDirty_i));

  // stores only land in a line that is already resident
  dirtyOnValid: assert property (@(posedge clk) disable iff (!rst_n)
    setDirty_i |-> valid_o[hitWay_i]);

endmodule

// File: verilog/refillBuffer.sv
`timescale 1ns/1ps

module refillBuffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         memRdDataValid_i,
  input  logic [dcachePkg::WordW-1:0]  memRdData_i,
  input  logic                         memRdLast_i,
  output logic [dcachePkg::LineW-1:0]  line_o,
  output logic                         done_o
);

  localparam int CntW = $clog2(dcachePkg::BeatsPerLine);

  logic [CntW-1:0] beatCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= memRdDataValid_i && memRdLast_i;
      if (memRdDataValid_i) begin
        beatCnt <= memRdLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (memRdDataValid_i) begin
      line_o[beatCnt*dcachePkg::WordW +: dcachePkg::WordW] <= memRdData_i;
    end
  end

  lastOnFourthBeat: assert property (@(posedge clk) disable iff (!rst_n)
    memRdLast_i |-> memRdDataValid_i && beatCnt == CntW'(dcachePkg::BeatsPerLine - 1));

endmodule

// File: verilog/storeMerge.sv
`timescale 1ns/1ps

module storeMerge (
  input  dcachePkg::cpuReq_t     req_i,
  output dcachePkg::lineWrite_t  write_o
);

  localparam int WordsPerLine = dcachePkg::LineW / dcachePkg::WordW;
  localparam int BytesPerWord = dcachePkg::WordW / 8;

  logic [2:0]                   byteOff;
  logic [1:0]                   wordSel;
  logic [dcachePkg::WordW-1:0]  wordData;
  logic [BytesPerWord-1:0]      byteMask;
  logic [dcachePkg::WordW-1:0]  wordMask;

  assign byteOff  = req_i.addr[2:0];
  assign wordSel  = req_i.addr[4:3];
  // align data and byte enables to the byte offset inside the word
  assign wordData = req_i.wrData << {byteOff, 3'b000};
  assign byteMask = req_i.wrMask << byteOff;

  always_comb begin
    for (int b = 0; b < BytesPerWord; b++) begin
      wordMask[b*8 +: 8] = {8{byteMask[b]}};
    end
    for (int w = 0; w < WordsPerLine; w++) begin
      write_o.data[w*dcachePkg::WordW +: dcachePkg::WordW]    = (w == wordSel) ? wordData : '0;
      write_o.bitMask[w*dcachePkg::WordW +: dcachePkg::WordW] = (w == wordSel) ? wordMask : '0;
    end
  end

endmodule

// File: verilog/wayArray.sv
`timescale 1ns/1ps

module wayArray #(
  parameter int  Depth   = 64,
  parameter type Payload = logic [31:0]
) (
  input  logic                       clk,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [$clog2(Depth)-1:0]   addr_i,
  input  Payload                     d_i,
  input  logic [$bits(Payload)-1:0]  bitMask_i,
  output Payload                     q_o
);

  localparam int Width = $bits(Payload);

  logic [Width-1:0] mem [Depth];
  logic [Width-1:0] qReg;

  // read returns the old contents when the same entry is written
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= (mem[addr_i] & ~bitMask_i) | (Width'(d_i) & bitMask_i);
      end
      qReg <= mem[addr_i];
    end
  end

  assign q_o = Payload'(qReg);

endmodule
